//--- mc_xfer_pkg.sv
`default_nettype none

package mc_xfer_pkg;

    // ========================================================================
    // Local SRAM geometry
    // ========================================================================

    localparam int SRAM_DEPTH     = 16384;
    localparam int BYTES_PER_WORD = 4;

    typedef logic [$clog2(SRAM_DEPTH)-1:0] sram_addr_t;

    // One SRAM word, same width as a DRAM beat
    typedef logic [31:0] word_t;

    // ========================================================================
    // Transfer records
    // ========================================================================

    // Strided tile fetch, rows land back to back in SRAM
    typedef struct packed {
        logic [31:0] dram_addr;
        logic [15:0] row_stride;
        logic [15:0] row_bytes;
        logic [15:0] rows;
        sram_addr_t  sram_addr;
    } fetch_req_t;

    typedef struct packed {
        logic       en;
        sram_addr_t addr;
        word_t      data;
    } sram_wr_t;

    // Handed to the compute engine once both operand tiles are resident
    typedef struct packed {
        sram_addr_t  sram_addr_a;
        sram_addr_t  sram_addr_b;
        logic [15:0] m_dim;
        logic [15:0] n_dim;
        logic [15:0] k_dim;
    } tile_desc_t;

endpackage

`default_nettype wire

//--- mc_cfg_pkg.sv
`default_nettype none

package mc_cfg_pkg;

    typedef logic [15:0] dim_t;
    typedef logic [31:0] dram_addr_t;
    typedef logic [7:0]  reg_addr_t;
    typedef logic [31:0] reg_data_t;

    localparam dim_t MAX_TILE_DIM = 16'd64;

    // ========================================================================
    // Register map
    // ========================================================================

    localparam reg_addr_t REG_CTRL        = 8'h00;
    localparam reg_addr_t REG_STATUS      = 8'h04;
    localparam reg_addr_t REG_MATRIX_M    = 8'h08;
    localparam reg_addr_t REG_MATRIX_N    = 8'h0C;
    localparam reg_addr_t REG_MATRIX_K    = 8'h10;
    localparam reg_addr_t REG_TILE_M      = 8'h14;
    localparam reg_addr_t REG_TILE_N      = 8'h18;
    localparam reg_addr_t REG_TILE_K      = 8'h1C;
    localparam reg_addr_t REG_DRAM_BASE_A = 8'h20;
    localparam reg_addr_t REG_DRAM_BASE_B = 8'h24;
    localparam reg_addr_t REG_SRAM_BASE_A = 8'h28;
    localparam reg_addr_t REG_SRAM_BASE_B = 8'h2C;
    localparam reg_addr_t REG_PERF_CYCLES = 8'h30;
    localparam reg_addr_t REG_PERF_BEATS  = 8'h34;
    localparam reg_addr_t REG_PERF_TILES  = 8'h38;

    typedef struct packed {
        dim_t                    matrix_m;
        dim_t                    matrix_n;
        dim_t                    matrix_k;
        dim_t                    tile_m;
        dim_t                    tile_n;
        dim_t                    tile_k;
        dram_addr_t              dram_base_a;
        dram_addr_t              dram_base_b;
        mc_xfer_pkg::sram_addr_t sram_base_a;
        mc_xfer_pkg::sram_addr_t sram_base_b;
    } mc_cfg_t;

endpackage

`default_nettype wire

//--- mc_config_regs.sv
`timescale 1ns/1ps
`default_nettype none

module mc_config_regs (
    input  logic                  clk,
    input  logic                  rst_n,
    input  mc_cfg_pkg::reg_addr_t cfg_addr,
    input  mc_cfg_pkg::reg_data_t cfg_wdata,
    input  logic                  cfg_wen,
    input  logic                  cfg_ren,
    output mc_cfg_pkg::reg_data_t cfg_rdata,
    output mc_cfg_pkg::mc_cfg_t   cfg,
    output logic                  start,
    input  logic                  busy,
    input  logic                  done,
    input  logic                  error,
    input  mc_cfg_pkg::reg_data_t perf_cycles,
    input  mc_cfg_pkg::reg_data_t perf_beats,
    input  mc_cfg_pkg::reg_data_t perf_tiles
);

    mc_cfg_pkg::reg_data_t rd_mux;

    // ========================================================================
    // Host writes
    // ========================================================================

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cfg   <= '0;
            start <= 1'b0;
        end else begin
            // Start is write-one, never stored
            start <= cfg_wen && (cfg_addr == mc_cfg_pkg::REG_CTRL) && cfg_wdata[0];
            if (cfg_wen) begin
                case (cfg_addr)
                    mc_cfg_pkg::REG_MATRIX_M: cfg.matrix_m <= mc_cfg_pkg::dim_t'(cfg_wdata);
                    mc_cfg_pkg::REG_MATRIX_N: cfg.matrix_n <= mc_cfg_pkg::dim_t'(cfg_wdata);
                    mc_cfg_pkg::REG_MATRIX_K: cfg.matrix_k <= mc_cfg_pkg::dim_t'(cfg_wdata);
                    mc_cfg_pkg::REG_TILE_M:   cfg.tile_m   <= mc_cfg_pkg::dim_t'(cfg_wdata);
                    mc_cfg_pkg::REG_TILE_N:   cfg.tile_n   <= mc_cfg_pkg::dim_t'(cfg_wdata);
                    mc_cfg_pkg::REG_TILE_K:   cfg.tile_k   <= mc_cfg_pkg::dim_t'(cfg_wdata);
                    mc_cfg_pkg::REG_DRAM_BASE_A: cfg.dram_base_a <= cfg_wdata;
                    mc_cfg_pkg::REG_DRAM_BASE_B: cfg.dram_base_b <= cfg_wdata;
                    mc_cfg_pkg::REG_SRAM_BASE_A:
                        cfg.sram_base_a <= mc_xfer_pkg::sram_addr_t'(cfg_wdata);
                    mc_cfg_pkg::REG_SRAM_BASE_B:
                        cfg.sram_base_b <= mc_xfer_pkg::sram_addr_t'(cfg_wdata);
                    default: ;
                endcase
            end
        end
    end

    // ========================================================================
    // Readback
    // ========================================================================

    // CTRL reads back as zero along with unmapped offsets
    always_comb begin
        case (cfg_addr)
            mc_cfg_pkg::REG_STATUS:      rd_mux = {29'd0, error, done, busy};
            mc_cfg_pkg::REG_MATRIX_M:    rd_mux = mc_cfg_pkg::reg_data_t'(cfg.matrix_m);
            mc_cfg_pkg::REG_MATRIX_N:    rd_mux = mc_cfg_pkg::reg_data_t'(cfg.matrix_n);
            mc_cfg_pkg::REG_MATRIX_K:    rd_mux = mc_cfg_pkg::reg_data_t'(cfg.matrix_k);
            mc_cfg_pkg::REG_TILE_M:      rd_mux = mc_cfg_pkg::reg_data_t'(cfg.tile_m);
            mc_cfg_pkg::REG_TILE_N:      rd_mux = mc_cfg_pkg::reg_data_t'(cfg.tile_n);
            mc_cfg_pkg::REG_TILE_K:      rd_mux = mc_cfg_pkg::reg_data_t'(cfg.tile_k);
            mc_cfg_pkg::REG_DRAM_BASE_A: rd_mux = cfg.dram_base_a;
            mc_cfg_pkg::REG_DRAM_BASE_B: rd_mux = cfg.dram_base_b;
            mc_cfg_pkg::REG_SRAM_BASE_A: rd_mux = mc_cfg_pkg::reg_data_t'(cfg.sram_base_a);
            mc_cfg_pkg::REG_SRAM_BASE_B: rd_mux = mc_cfg_pkg::reg_data_t'(cfg.sram_base_b);
            mc_cfg_pkg::REG_PERF_CYCLES: rd_mux = perf_cycles;
            mc_cfg_pkg::REG_PERF_BEATS:  rd_mux = perf_beats;
            mc_cfg_pkg::REG_PERF_TILES:  rd_mux = perf_tiles;
            default:                     rd_mux = '0;
        endcase
    end

    // Holds the last read value between reads
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cfg_rdata <= '0;
        end else if (cfg_ren) begin
            cfg_rdata <= rd_mux;
        end
    end

endmodule

`default_nettype wire

//--- mc_tile_scheduler.sv
`timescale 1ns/1ps
`default_nettype none

module mc_tile_scheduler (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    start,
    input  mc_cfg_pkg::mc_cfg_t     cfg,
    output mc_xfer_pkg::fetch_req_t fetch_req,
    output logic                    fetch_valid,
    input  logic                    fetch_ready,
    input  logic                    fetch_done,
    output mc_xfer_pkg::tile_desc_t tile_desc,
    output logic                    tile_valid,
    input  logic                    tile_ready,
    input  logic                    tile_done,
    output logic                    busy,
    output logic                    done,
    output logic                    error
);

    typedef enum logic [2:0] {
        S_IDLE,
        S_REQ_A,
        S_WAIT_A,
        S_REQ_B,
        S_WAIT_B,
        S_TILE,
        S_COMPUTE
    } state_t;

    state_t                 state;
    // Element offsets of the current step, mi*tile_m and so on
    mc_cfg_pkg::dim_t       m_off;
    mc_cfg_pkg::dim_t       n_off;
    mc_cfg_pkg::dim_t       k_off;
    logic                   last_m;
    logic                   last_n;
    logic                   last_k;
    logic                   cfg_bad;
    mc_cfg_pkg::dram_addr_t addr_a;
    mc_cfg_pkg::dram_addr_t addr_b;

    assign cfg_bad =
        (cfg.matrix_m == '0) || (cfg.matrix_n == '0) || (cfg.matrix_k == '0) ||
        (cfg.tile_m == '0) || (cfg.tile_n == '0) || (cfg.tile_k == '0) ||
        (cfg.tile_m > mc_cfg_pkg::MAX_TILE_DIM) ||
        (cfg.tile_n > mc_cfg_pkg::MAX_TILE_DIM) ||
        (cfg.tile_k > mc_cfg_pkg::MAX_TILE_DIM) ||
        ((cfg.matrix_m % cfg.tile_m) != '0) ||
        ((cfg.matrix_n % cfg.tile_n) != '0) ||
        ((cfg.matrix_k % cfg.tile_k) != '0) ||
        ((cfg.tile_k % mc_xfer_pkg::BYTES_PER_WORD) != 0) ||
        ((cfg.tile_n % mc_xfer_pkg::BYTES_PER_WORD) != 0);

    // Matrices are a whole number of tiles, so these sums never wrap
    assign last_m = (m_off + cfg.tile_m) == cfg.matrix_m;
    assign last_n = (n_off + cfg.tile_n) == cfg.matrix_n;
    assign last_k = (k_off + cfg.tile_k) == cfg.matrix_k;

    // Row-major byte addresses of the tile corners
    assign addr_a = cfg.dram_base_a + mc_cfg_pkg::dram_addr_t'(m_off) * cfg.matrix_k + k_off;
    assign addr_b = cfg.dram_base_b + mc_cfg_pkg::dram_addr_t'(k_off) * cfg.matrix_n + n_off;

    assign busy        = state != S_IDLE;
    assign fetch_valid = (state == S_REQ_A) || (state == S_REQ_B);
    assign tile_valid  = state == S_TILE;

    always_comb begin
        if (state == S_REQ_B) begin
            fetch_req.dram_addr  = addr_b;
            fetch_req.row_stride = cfg.matrix_n;
            fetch_req.row_bytes  = cfg.tile_n;
            fetch_req.rows       = cfg.tile_k;
            fetch_req.sram_addr  = cfg.sram_base_b;
        end else begin
            fetch_req.dram_addr  = addr_a;
            fetch_req.row_stride = cfg.matrix_k;
            fetch_req.row_bytes  = cfg.tile_k;
            fetch_req.rows       = cfg.tile_m;
            fetch_req.sram_addr  = cfg.sram_base_a;
        end
    end

    assign tile_desc = '{
        sram_addr_a: cfg.sram_base_a,
        sram_addr_b: cfg.sram_base_b,
        m_dim:       cfg.tile_m,
        n_dim:       cfg.tile_n,
        k_dim:       cfg.tile_k
    };

    // ========================================================================
    // Tile loop, ki innermost, then ni, then mi
    // ========================================================================

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= S_IDLE;
            done  <= 1'b0;
            error <= 1'b0;
            m_off <= '0;
            n_off <= '0;
            k_off <= '0;
        end else begin
            case (state)
                S_IDLE: begin
                    if (start) begin
                        done  <= 1'b0;
                        error <= cfg_bad;
                        m_off <= '0;
                        n_off <= '0;
                        k_off <= '0;
                        if (!cfg_bad) state <= S_REQ_A;
                    end
                end
                S_REQ_A:  if (fetch_ready) state <= S_WAIT_A;
                S_WAIT_A: if (fetch_done) state <= S_REQ_B;
                S_REQ_B:  if (fetch_ready) state <= S_WAIT_B;
                S_WAIT_B: if (fetch_done) state <= S_TILE;
                S_TILE:   if (tile_ready) state <= S_COMPUTE;
                S_COMPUTE: begin
                    if (tile_done) begin
                        state <= S_REQ_A;
                        k_off <= last_k ? '0 : k_off + cfg.tile_k;
                        if (last_k) n_off <= last_n ? '0 : n_off + cfg.tile_n;
                        if (last_k && last_n) begin
                            m_off <= m_off + cfg.tile_m;
                            if (last_m) begin
                                state <= S_IDLE;
                                done  <= 1'b1;
                            end
                        end
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- mc_dram_reader.sv
`timescale 1ns/1ps
`default_nettype none

module mc_dram_reader (
    input  logic                    clk,
    input  logic                    rst_n,
    input  mc_xfer_pkg::fetch_req_t fetch_req,
    input  logic                    fetch_valid,
    output logic                    fetch_ready,
    output logic                    fetch_done,
    output logic                    dram_req_valid,
    input  logic                    dram_req_ready,
    output mc_cfg_pkg::dram_addr_t  dram_req_addr,
    output mc_cfg_pkg::dim_t        dram_req_bytes,
    input  logic                    dram_rvalid,
    output logic                    dram_rready,
    input  mc_xfer_pkg::word_t      dram_rdata,
    input  logic                    dram_rlast,
    output mc_xfer_pkg::sram_wr_t   sram_wr
);

    typedef enum logic [1:0] {
        R_IDLE,
        R_REQ,
        R_DATA,
        R_FLUSH
    } state_t;

    state_t                  state;
    logic                    beat;
    mc_cfg_pkg::dram_addr_t  row_addr;
    mc_cfg_pkg::dim_t        row_stride;
    mc_cfg_pkg::dim_t        row_bytes;
    mc_cfg_pkg::dim_t        rows_left;
    mc_xfer_pkg::sram_addr_t wr_ptr;
    logic                    wr_en_q;
    mc_xfer_pkg::sram_addr_t wr_addr_q;
    mc_xfer_pkg::word_t      wr_data_q;

    assign beat           = dram_rvalid && dram_rready;
    assign fetch_ready    = state == R_IDLE;
    assign dram_req_valid = state == R_REQ;
    assign dram_rready    = state == R_DATA;
    assign dram_req_addr  = row_addr;
    assign dram_req_bytes = row_bytes;
    assign sram_wr        = '{en: wr_en_q, addr: wr_addr_q, data: wr_data_q};

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state      <= R_IDLE;
            fetch_done <= 1'b0;
            wr_en_q    <= 1'b0;
        end else begin
            fetch_done <= 1'b0;
            wr_en_q    <= beat;
            case (state)
                R_IDLE: if (fetch_valid) state <= R_REQ;
                R_REQ:  if (dram_req_ready) state <= R_DATA;
                R_DATA: begin
                    if (beat && dram_rlast) begin
                        state <= (rows_left == 16'd1) ? R_FLUSH : R_REQ;
                    end
                end
                // Last beat is being written this cycle
                R_FLUSH: begin
                    state      <= R_IDLE;
                    fetch_done <= 1'b1;
                end
                default: state <= R_IDLE;
            endcase
        end
    end

    // Row walk and SRAM write payload
    always_ff @(posedge clk) begin
        if ((state == R_IDLE) && fetch_valid) begin
            row_addr   <= fetch_req.dram_addr;
            row_stride <= fetch_req.row_stride;
            row_bytes  <= fetch_req.row_bytes;
            rows_left  <= fetch_req.rows;
            wr_ptr     <= fetch_req.sram_addr;
        end
        if (beat) begin
            wr_addr_q <= wr_ptr;
            wr_data_q <= dram_rdata;
            wr_ptr    <= wr_ptr + 1'b1;
            if (dram_rlast) begin
                row_addr  <= row_addr + row_stride;
                rows_left <= rows_left - 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

//--- mc_perf_counters.sv
`timescale 1ns/1ps
`default_nettype none

module mc_perf_counters (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  start,
    input  logic                  busy,
    input  logic                  beat,
    input  logic                  tile_done,
    output mc_cfg_pkg::reg_data_t perf_cycles,
    output mc_cfg_pkg::reg_data_t perf_beats,
    output mc_cfg_pkg::reg_data_t perf_tiles
);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            perf_cycles <= '0;
            perf_beats  <= '0;
            perf_tiles  <= '0;
        end else if (start) begin
            perf_cycles <= '0;
            perf_beats  <= '0;
            perf_tiles  <= '0;
        end else begin
            if (busy) perf_cycles <= perf_cycles + 1'b1;
            if (beat) perf_beats <= perf_beats + 1'b1;
            // Stray completions outside a run are not tiles
            if (tile_done && busy) perf_tiles <= perf_tiles + 1'b1;
        end
    end

endmodule

`default_nettype wire

//--- mc_memory_controller.sv
`timescale 1ns/1ps
`default_nettype none

module mc_memory_controller (
    input  logic                    clk,
    input  logic                    rst_n,
    // Host register port
    input  mc_cfg_pkg::reg_addr_t   cfg_addr,
    input  mc_cfg_pkg::reg_data_t   cfg_wdata,
    input  logic                    cfg_wen,
    input  logic                    cfg_ren,
    output mc_cfg_pkg::reg_data_t   cfg_rdata,
    // DRAM read request and response
    output logic                    dram_req_valid,
    input  logic                    dram_req_ready,
    output mc_cfg_pkg::dram_addr_t  dram_req_addr,
    output mc_cfg_pkg::dim_t        dram_req_bytes,
    input  logic                    dram_rvalid,
    output logic                    dram_rready,
    input  mc_xfer_pkg::word_t      dram_rdata,
    input  logic                    dram_rlast,
    // Local SRAM write port
    output mc_xfer_pkg::sram_wr_t   sram_wr,
    // Compute engine
    output mc_xfer_pkg::tile_desc_t tile_desc,
    output logic                    tile_valid,
    input  logic                    tile_ready,
    input  logic                    tile_done,
    output logic                    done,
    output logic                    error
);

    // ========================================================================
    // Internal wiring
    // ========================================================================

    mc_cfg_pkg::mc_cfg_t     cfg;
    logic                    start;
    logic                    busy;
    mc_xfer_pkg::fetch_req_t fetch_req;
    logic                    fetch_valid;
    logic                    fetch_ready;
    logic                    fetch_done;
    logic                    beat;
    mc_cfg_pkg::reg_data_t   perf_cycles;
    mc_cfg_pkg::reg_data_t   perf_beats;
    mc_cfg_pkg::reg_data_t   perf_tiles;

    assign beat = dram_rvalid && dram_rready;

    // Port names match the local nets one for one
    mc_config_regs    u_config_regs    (.*);
    mc_tile_scheduler u_tile_scheduler (.*);
    mc_dram_reader    u_dram_reader    (.*);
    mc_perf_counters  u_perf_counters  (.*);

endmodule

`default_nettype wire

//--- tb_mc_memory_controller.sv
`timescale 1ns/1ps
`default_nettype none

module tb_mc_memory_controller;

    localparam int CLK_PERIOD       = 40;
    localparam int NUM_TESTS        = 7;
    localparam int WORD_CYCLE_BOUND = 32;
    localparam int TEST_OVERHEAD    = 3000;

    typedef struct packed {
        logic [15:0] m, n, k;
        logic [15:0] tm, tn, tk;
        logic [31:0] base_a, base_b;
        logic [15:0] sram_a, sram_b;
        logic        bad;
    } test_row_t;

    // ========================================================================
    // Stimulus table
    // ========================================================================

    test_row_t tests [NUM_TESTS] = '{
        //  M      N      K      tm     tn     tk     dram A        dram B
        //  sram A    sram B    bad
        '{16'd8, 16'd8, 16'd8, 16'd4, 16'd4, 16'd4, 32'h0000_1000, 32'h0000_2000,
          16'h0000, 16'h0100, 1'b0},
        '{16'd12, 16'd8, 16'd8, 16'd8, 16'd4, 16'd4, 32'h0000_1000, 32'h0000_2000,
          16'h0000, 16'h0100, 1'b1},
        '{16'd16, 16'd16, 16'd32, 16'd8, 16'd8, 16'd16, 32'h0003_4010, 32'h0001_7f00,
          16'h0200, 16'h3f00, 1'b0},
        '{16'd4, 16'd12, 16'd4, 16'd4, 16'd6, 16'd4, 32'h0000_0000, 32'h0000_0400,
          16'h0000, 16'h0100, 1'b1},
        '{16'd4, 16'd8, 16'd12, 16'd4, 16'd8, 16'd4, 32'h0000_0010, 32'h0000_5000,
          16'h0040, 16'h0080, 1'b0},
        '{16'd80, 16'd80, 16'd80, 16'd80, 16'd80, 16'd80, 32'h0000_0000, 32'h0001_0000,
          16'h0000, 16'h1000, 1'b1},
        '{16'd64, 16'd64, 16'd64, 16'd64, 16'd64, 16'd64, 32'h0002_0300, 32'h0004_8000,
          16'h1000, 16'h2000, 1'b0}
    };

    logic                    clk;
    logic                    rst_n;
    mc_cfg_pkg::reg_addr_t   cfg_addr;
    mc_cfg_pkg::reg_data_t   cfg_wdata;
    logic                    cfg_wen;
    logic                    cfg_ren;
    mc_cfg_pkg::reg_data_t   cfg_rdata;
    logic                    dram_req_valid;
    logic                    dram_req_ready = 1'b0;
    mc_cfg_pkg::dram_addr_t  dram_req_addr;
    mc_cfg_pkg::dim_t        dram_req_bytes;
    logic                    dram_rvalid = 1'b0;
    logic                    dram_rready;
    mc_xfer_pkg::word_t      dram_rdata = '0;
    logic                    dram_rlast = 1'b0;
    mc_xfer_pkg::sram_wr_t   sram_wr;
    mc_xfer_pkg::tile_desc_t tile_desc;
    logic                    tile_valid;
    logic                    tile_ready = 1'b0;
    logic                    tile_done = 1'b0;
    logic                    done;
    logic                    error;

    logic [31:0]        lfsr = 32'h5c78;
    mc_xfer_pkg::word_t sram [mc_xfer_pkg::SRAM_DEPTH];
    test_row_t          cur;
    int                 hs_count = 0;
    int                 hs_base = 0;
    int                 valid_cycles = 0;
    int                 check_count = 0;
    int                 error_count = 0;

    mc_memory_controller dut (.*);

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // Fibonacci LFSR, taps 32 22 2 1
    function automatic logic lfsr_bit();
        logic fb;
        fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
        lfsr = {lfsr[30:0], fb};
        return fb;
    endfunction

    function automatic logic [7:0] mem_byte(input logic [31:0] a);
        return a[7:0] ^ a[15:8];
    endfunction

    // Lowest address in bits [7:0]
    function automatic logic [31:0] beat_word(input logic [31:0] a);
        return {mem_byte(a + 3), mem_byte(a + 2), mem_byte(a + 1), mem_byte(a)};
    endfunction

    function automatic int step_count(input test_row_t r);
        return (r.m / r.tm) * (r.n / r.tn) * (r.k / r.tk);
    endfunction

    function automatic int words_fetched(input test_row_t r);
        if (r.bad) return 0;
        return step_count(r) * (r.tm * r.tk + r.tk * r.tn) / 4;
    endfunction

    task automatic check(input string name, input logic [31:0] exp, input logic [31:0] got);
        check_count++;
        if (exp !== got) begin
            error_count++;
            $display("error %s expected %h got %h", name, exp, got);
        end
    endtask

    // Both operand tiles against the DRAM contents of step number step
    task automatic check_tiles(input int step);
        int kt, nt, mi, ni, ki, wa, wb, w;
        logic [31:0] addr;
        kt = cur.k / cur.tk;
        nt = cur.n / cur.tn;
        ki = step % kt;
        ni = (step / kt) % nt;
        mi = step / (kt * nt);
        check("tile_desc.sram_addr_a", cur.sram_a, tile_desc.sram_addr_a);
        check("tile_desc.sram_addr_b", cur.sram_b, tile_desc.sram_addr_b);
        check("tile_desc.m_dim", cur.tm, tile_desc.m_dim);
        check("tile_desc.n_dim", cur.tn, tile_desc.n_dim);
        check("tile_desc.k_dim", cur.tk, tile_desc.k_dim);
        wa = cur.tk / 4;
        for (w = 0; w < cur.tm * wa; w++) begin
            addr = cur.base_a + (mi * cur.tm + w / wa) * cur.k + ki * cur.tk + (w % wa) * 4;
            check("sram_a_word", beat_word(addr), sram[(cur.sram_a + w) % 16384]);
        end
        wb = cur.tn / 4;
        for (w = 0; w < cur.tk * wb; w++) begin
            addr = cur.base_b + (ki * cur.tk + w / wb) * cur.n + ni * cur.tn + (w % wb) * 4;
            check("sram_b_word", beat_word(addr), sram[(cur.sram_b + w) % 16384]);
        end
    endtask

    // ========================================================================
    // DRAM, SRAM and compute engine models
    // ========================================================================

    always @(posedge clk) begin : models
        logic        rd_active;
        logic [31:0] rd_addr;
        int          rd_left;
        logic        accepted;
        logic        computing;
        int          done_wait;
        if (rst_n) begin
            if (sram_wr.en) sram[sram_wr.addr] = sram_wr.data;
            // Request channel with random ready delay
            if (dram_req_valid && dram_req_ready) begin
                rd_active = 1'b1;
                rd_addr   = dram_req_addr;
                rd_left   = dram_req_bytes / 4;
                dram_req_ready <= 1'b0;
            end else if (dram_req_valid) begin
                dram_req_ready <= lfsr_bit();
            end
            // Response beats with random gaps
            accepted = dram_rvalid && dram_rready;
            if (accepted) begin
                rd_addr = rd_addr + 4;
                rd_left--;
                if (rd_left == 0) rd_active = 1'b0;
                dram_rvalid <= 1'b0;
                dram_rlast  <= 1'b0;
            end
            if (rd_active && (accepted || !dram_rvalid)) begin
                if (lfsr_bit()) begin
                    dram_rvalid <= 1'b1;
                    dram_rdata  <= beat_word(rd_addr);
                    dram_rlast  <= rd_left == 1;
                end else begin
                    dram_rvalid <= 1'b0;
                end
            end
            // Compute engine
            if (tile_valid) valid_cycles++;
            tile_done <= 1'b0;
            if (computing) begin
                if (done_wait == 0) begin
                    tile_done <= 1'b1;
                    computing = 1'b0;
                end else begin
                    done_wait--;
                end
            end else if (tile_valid && tile_ready) begin
                check_tiles(hs_count - hs_base);
                hs_count++;
                tile_ready <= 1'b0;
                computing = 1'b1;
                done_wait = {lfsr_bit(), lfsr_bit(), lfsr_bit()};
            end else if (tile_valid) begin
                tile_ready <= lfsr_bit();
            end
        end else begin
            rd_active = 1'b0;
            computing = 1'b0;
        end
    end

    // ========================================================================
    // Host register access
    // ========================================================================

    task automatic reg_write(input logic [7:0] addr, input logic [31:0] data);
        @(posedge clk);
        cfg_addr  <= addr;
        cfg_wdata <= data;
        cfg_wen   <= 1'b1;
        @(posedge clk);
        cfg_wen <= 1'b0;
    endtask

    task automatic reg_read(input logic [7:0] addr, output logic [31:0] data);
        @(posedge clk);
        cfg_addr <= addr;
        cfg_ren  <= 1'b1;
        @(posedge clk);
        cfg_ren <= 1'b0;
        @(negedge clk);
        data = cfg_rdata;
    endtask

    task automatic run_test(input int t);
        logic [7:0]  addrs [10];
        logic [31:0] vals [10];
        logic [31:0] rd;
        int          errs_before;
        int          i;
        errs_before = error_count;
        cur = tests[t];
        addrs = '{mc_cfg_pkg::REG_MATRIX_M, mc_cfg_pkg::REG_MATRIX_N, mc_cfg_pkg::REG_MATRIX_K,
                  mc_cfg_pkg::REG_TILE_M, mc_cfg_pkg::REG_TILE_N, mc_cfg_pkg::REG_TILE_K,
                  mc_cfg_pkg::REG_DRAM_BASE_A, mc_cfg_pkg::REG_DRAM_BASE_B,
                  mc_cfg_pkg::REG_SRAM_BASE_A, mc_cfg_pkg::REG_SRAM_BASE_B};
        vals = '{cur.m, cur.n, cur.k, cur.tm, cur.tn, cur.tk,
                 cur.base_a, cur.base_b, cur.sram_a, cur.sram_b};
        for (i = 0; i < 10; i++) reg_write(addrs[i], vals[i]);
        for (i = 0; i < 10; i++) begin
            reg_read(addrs[i], rd);
            check("cfg_rdata", vals[i], rd);
        end
        reg_read(8'h3C, rd);
        check("cfg_rdata unmapped", 32'h0, rd);
        reg_read(8'hF0, rd);
        check("cfg_rdata unmapped", 32'h0, rd);
        hs_base = hs_count;
        i = valid_cycles;
        reg_write(mc_cfg_pkg::REG_CTRL, 32'h1);
        if (cur.bad) begin
            repeat (20) @(negedge clk);
            reg_read(mc_cfg_pkg::REG_STATUS, rd);
            check("status", 32'h4, rd);
            check("error", 32'h1, error);
            check("done", 32'h0, done);
            check("tile_valid cycles", 0, valid_cycles - i);
        end else begin
            repeat (2) @(negedge clk);
            while (done !== 1'b1) @(negedge clk);
            reg_read(mc_cfg_pkg::REG_STATUS, rd);
            check("status", 32'h2, rd);
            check("error", 32'h0, error);
            check("tile handshakes", step_count(cur), hs_count - hs_base);
            reg_read(mc_cfg_pkg::REG_PERF_TILES, rd);
            check("perf_tiles", step_count(cur), rd);
            reg_read(mc_cfg_pkg::REG_PERF_BEATS, rd);
            check("perf_beats", words_fetched(cur), rd);
            reg_read(mc_cfg_pkg::REG_PERF_CYCLES, rd);
            check("perf_cycles nonzero", 32'h1, rd != 0);
        end
        $display("test %0d M=%0d N=%0d K=%0d tile %0dx%0dx%0d: %s", t, cur.m, cur.n, cur.k,
                 cur.tm, cur.tn, cur.tk, (error_count == errs_before) ? "ok" : "mismatch");
    endtask

    initial begin : main
        int t;
        rst_n     = 1'b0;
        cfg_addr  = '0;
        cfg_wdata = '0;
        cfg_wen   = 1'b0;
        cfg_ren   = 1'b0;
        repeat (5) @(posedge clk);
        rst_n <= 1'b1;
        for (t = 0; t < NUM_TESTS; t++) run_test(t);
        $display("%0d tests, %0d checks, %0d errors", NUM_TESTS, check_count, error_count);
        if (error_count == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

    // Bound grows with the words the table fetches
    initial begin : watchdog
        longint limit;
        int     i;
        limit = 0;
        for (i = 0; i < NUM_TESTS; i++) begin
            limit += words_fetched(tests[i]) * WORD_CYCLE_BOUND + TEST_OVERHEAD;
        end
        #(limit * CLK_PERIOD);
        $display("timeout after %0d cycles, the run did not finish", limit);
        $display("tests failed");
        $finish;
    end

endmodule

`default_nettype wire

//--- compile.f
mc_xfer_pkg.sv
mc_cfg_pkg.sv
mc_config_regs.sv
mc_tile_scheduler.sv
mc_dram_reader.sv
mc_perf_counters.sv
mc_memory_controller.sv
tb_mc_memory_controller.sv

//--- Bender.yml
package:
  name: mc_memory_controller

sources:
  - mc_xfer_pkg.sv
  - mc_cfg_pkg.sv
  - mc_config_regs.sv
  - mc_tile_scheduler.sv
  - mc_dram_reader.sv
  - mc_perf_counters.sv
  - mc_memory_controller.sv
  - target: test
    files:
      - tb_mc_memory_controller.sv
